// File: common/synth_pkg.sv
package synth_pkg;

    localparam int V_OSC    = 4;
    localparam int ADR_W    = 7;
    localparam int DATA_W   = 8;
    localparam int SAMPLE_W = 16;
    localparam int NAME_LEN = 16;

    // every oscillator and every matrix row owns 16 addresses
    localparam int OSC_SLICE = 16;

    // parameters scale a signal by value/128
    localparam int PRM_SHIFT = 7;
    localparam logic signed [DATA_W-1:0] PRM_MAX = 8'sd127;

    // four oscillator contributions need two extra bits plus headroom
    localparam int MIX_SUM_W = SAMPLE_W + 3;
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 16'sh7FFF;
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 16'sh8000;

    typedef enum logic [1:0] {
        BANK_OSC  = 2'd0,
        BANK_COM  = 2'd1,
        BANK_MAT1 = 2'd2,
        BANK_MAT2 = 2'd3
    } param_bank_e;

    localparam logic [3:0] OFS_LVL       = 4'd2;
    localparam logic [3:0] OFS_MOD_OUT   = 4'd3;
    localparam logic [3:0] OFS_FEEDB_OUT = 4'd4;
    localparam logic [3:0] OFS_PAN       = 4'd7;
    localparam logic [3:0] OFS_MOD_IN    = 4'd10;
    localparam logic [3:0] OFS_FEEDB_IN  = 4'd11;

    localparam logic [ADR_W-1:0] ADR_M_VOL     = 7'd1;
    localparam logic [ADR_W-1:0] ADR_NAME_BASE = 7'd16;

    localparam logic [DATA_W-1:0] RST_LVL_LOW   = 8'h40;
    localparam logic [DATA_W-1:0] RST_PAN       = 8'h40;
    localparam logic [DATA_W-1:0] RST_M_VOL     = 8'h40;
    localparam logic [DATA_W-1:0] RST_NAME_CHAR = 8'd32;

    localparam logic [3:0] MIDI_CHANNEL   = 4'd0;
    localparam logic [3:0] MIDI_STATUS_CC = 4'hB;
    localparam logic [7:0] MIDI_RT_MIN    = 8'hF8;

    localparam logic [6:0] CC_NRPN_MSB   = 7'd99;
    localparam logic [6:0] CC_NRPN_LSB   = 7'd98;
    localparam logic [6:0] CC_DATA_ENTRY = 7'd6;

    typedef enum logic [1:0] {
        CC_IDLE     = 2'd0,
        CC_WAIT_NUM = 2'd1,
        CC_WAIT_VAL = 2'd2
    } cc_state_e;

endpackage

// File: common/param_wr_if.sv
interface param_wr_if;
    import synth_pkg::*;

    param_bank_e               bank;
    logic [ADR_W-1:0]          adr;
    logic signed [DATA_W-1:0]  wdata;
    // one-cycle strobe, the register file takes every write
    logic                      write;

    modport source (
        output bank,
        output adr,
        output wdata,
        output write
    );

    modport sink (
        input bank,
        input adr,
        input wdata,
        input write
    );

endinterface

// File: midi_ctrl/midi_cc_decoder.sv
module midi_cc_decoder (
    input  logic        data_clk,
    input  logic        reset_data_N,
    input  logic [7:0]  midi_byte,
    input  logic        midi_valid,
    param_wr_if.source  wr
);
    import synth_pkg::*;

    cc_state_e  state;
    logic [6:0] cc_num;
    logic       is_realtime;
    logic       is_status;
    logic       is_cc_status;
    logic       num_byte;
    logic       val_byte;

    // realtime bytes may appear anywhere and leave the parser untouched
    assign is_realtime  = (midi_byte >= MIDI_RT_MIN);
    assign is_status    = midi_byte[7];
    assign is_cc_status = (midi_byte == {MIDI_STATUS_CC, MIDI_CHANNEL});

    assign num_byte = midi_valid && !is_status && (state == CC_WAIT_NUM);
    assign val_byte = midi_valid && !is_status && (state == CC_WAIT_VAL);

    always_ff @(posedge data_clk) begin
        if (!reset_data_N) begin
            state    <= CC_IDLE;
            wr.write <= 1'b0;
            wr.bank  <= BANK_OSC;
            wr.adr   <= '0;
        end else begin
            wr.write <= 1'b0;
            if (midi_valid && !is_realtime) begin
                if (is_status) begin
                    state <= is_cc_status ? CC_WAIT_NUM : CC_IDLE;
                end else begin
                    case (state)
                        CC_WAIT_NUM: begin
                            state <= CC_WAIT_VAL;
                        end
                        CC_WAIT_VAL: begin
                            // running status, the next data byte is a controller number
                            state <= CC_WAIT_NUM;
                            case (cc_num)
                                CC_NRPN_MSB: begin
                                    wr.bank <= param_bank_e'(midi_byte[1:0]);
                                end
                                CC_NRPN_LSB: begin
                                    wr.adr <= midi_byte[ADR_W-1:0];
                                end
                                CC_DATA_ENTRY: begin
                                    wr.write <= 1'b1;
                                end
                                default: ;
                            endcase
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge data_clk) begin
        if (num_byte) begin
            cc_num <= midi_byte[6:0];
        end
        if (val_byte && (cc_num == CC_DATA_ENTRY)) begin
            wr.wdata <= {1'b0, midi_byte[6:0]};
        end
    end

    // a value byte is always preceded by a controller number byte
    a_write_single: assert property (
        @(posedge data_clk) disable iff (!reset_data_N)
        wr.write |=> !wr.write
    );

endmodule

// File: midi_ctrl/midi_ctrl_data.sv
module midi_ctrl_data (
    input  logic                                data_clk,
    input  logic                                reset_data_N,
    param_wr_if.sink                            wr,
    input  synth_pkg::param_bank_e              rd_bank,
    input  logic [synth_pkg::ADR_W-1:0]         rd_adr,
    input  logic                                read,
    output logic signed [synth_pkg::DATA_W-1:0] rd_data,
    output logic                                rd_valid,
    output logic signed [synth_pkg::DATA_W-1:0] osc_lvl [synth_pkg::V_OSC],
    output logic signed [synth_pkg::DATA_W-1:0] osc_pan [synth_pkg::V_OSC],
    output logic signed [synth_pkg::DATA_W-1:0] m_vol
);
    import synth_pkg::*;

    logic signed [DATA_W-1:0] osc_mod_out   [V_OSC];
    logic signed [DATA_W-1:0] osc_feedb_out [V_OSC];
    logic signed [DATA_W-1:0] osc_mod_in    [V_OSC];
    logic signed [DATA_W-1:0] osc_feedb_in  [V_OSC];
    logic signed [DATA_W-1:0] mat_buf1      [V_OSC][OSC_SLICE];
    logic signed [DATA_W-1:0] mat_buf2      [V_OSC][OSC_SLICE];
    logic        [DATA_W-1:0] patch_name    [NAME_LEN];

    logic [$clog2(V_OSC)-1:0]     wr_osc;
    logic [$clog2(OSC_SLICE)-1:0] wr_ofs;
    logic [$clog2(V_OSC)-1:0]     rd_osc;
    logic [$clog2(OSC_SLICE)-1:0] rd_ofs;
    logic signed [DATA_W-1:0]     rd_word;

    function automatic logic name_hit(input logic [ADR_W-1:0] a);
        return (a >= ADR_NAME_BASE) && (a < ADR_NAME_BASE + ADR_W'(NAME_LEN));
    endfunction

    function automatic logic [$clog2(NAME_LEN)-1:0] name_idx(input logic [ADR_W-1:0] a);
        logic [ADR_W-1:0] d;
        d = a - ADR_NAME_BASE;
        return d[$clog2(NAME_LEN)-1:0];
    endfunction

    // oscillator number sits in adr 5:4, adr 6 set is past the last slice
    assign wr_osc = wr.adr[5:4];
    assign wr_ofs = wr.adr[3:0];
    assign rd_osc = rd_adr[5:4];
    assign rd_ofs = rd_adr[3:0];

    always_ff @(posedge data_clk) begin
        if (!reset_data_N) begin
            for (int i = 0; i < V_OSC; i++) begin
                osc_lvl[i]       <= (i < 2) ? RST_LVL_LOW : '0;
                osc_mod_out[i]   <= '0;
                osc_feedb_out[i] <= '0;
                osc_pan[i]       <= RST_PAN;
                osc_mod_in[i]    <= '0;
                osc_feedb_in[i]  <= '0;
                for (int s = 0; s < OSC_SLICE; s++) begin
                    mat_buf1[i][s] <= '0;
                    mat_buf2[i][s] <= '0;
                end
            end
            m_vol <= RST_M_VOL;
            for (int n = 0; n < NAME_LEN; n++) begin
                patch_name[n] <= RST_NAME_CHAR;
            end
        end else if (wr.write) begin
            case (wr.bank)
                BANK_OSC: begin
                    if (!wr.adr[ADR_W-1]) begin
                        case (wr_ofs)
                            OFS_LVL:       osc_lvl[wr_osc]       <= wr.wdata;
                            OFS_MOD_OUT:   osc_mod_out[wr_osc]   <= wr.wdata;
                            OFS_FEEDB_OUT: osc_feedb_out[wr_osc] <= wr.wdata;
                            OFS_PAN:       osc_pan[wr_osc]       <= wr.wdata;
                            OFS_MOD_IN:    osc_mod_in[wr_osc]    <= wr.wdata;
                            OFS_FEEDB_IN:  osc_feedb_in[wr_osc]  <= wr.wdata;
                            default: ;
                        endcase
                    end
                end
                BANK_COM: begin
                    if (wr.adr == ADR_M_VOL) begin
                        m_vol <= wr.wdata;
                    end else if (name_hit(wr.adr)) begin
                        patch_name[name_idx(wr.adr)] <= wr.wdata;
                    end
                end
                BANK_MAT1: begin
                    if (!wr.adr[ADR_W-1]) begin
                        mat_buf1[wr_osc][wr_ofs] <= wr.wdata;
                    end
                end
                BANK_MAT2: begin
                    if (!wr.adr[ADR_W-1]) begin
                        mat_buf2[wr_osc][wr_ofs] <= wr.wdata;
                    end
                end
                default: ;
            endcase
        end
    end

    // anything outside the map reads as zero
    always_comb begin
        rd_word = '0;
        case (rd_bank)
            BANK_OSC: begin
                if (!rd_adr[ADR_W-1]) begin
                    case (rd_ofs)
                        OFS_LVL:       rd_word = osc_lvl[rd_osc];
                        OFS_MOD_OUT:   rd_word = osc_mod_out[rd_osc];
                        OFS_FEEDB_OUT: rd_word = osc_feedb_out[rd_osc];
                        OFS_PAN:       rd_word = osc_pan[rd_osc];
                        OFS_MOD_IN:    rd_word = osc_mod_in[rd_osc];
                        OFS_FEEDB_IN:  rd_word = osc_feedb_in[rd_osc];
                        default:       rd_word = '0;
                    endcase
                end
            end
            BANK_COM: begin
                if (rd_adr == ADR_M_VOL) begin
                    rd_word = m_vol;
                end else if (name_hit(rd_adr)) begin
                    rd_word = patch_name[name_idx(rd_adr)];
                end
            end
            BANK_MAT1: begin
                if (!rd_adr[ADR_W-1]) begin
                    rd_word = mat_buf1[rd_osc][rd_ofs];
                end
            end
            BANK_MAT2: begin
                if (!rd_adr[ADR_W-1]) begin
                    rd_word = mat_buf2[rd_osc][rd_ofs];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge data_clk) begin
        if (!reset_data_N) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= read;
        end
    end

    always_ff @(posedge data_clk) begin
        if (read) begin
            rd_data <= rd_word;
        end
    end

    a_rd_valid_after_read: assert property (
        @(posedge data_clk) disable iff (!reset_data_N)
        rd_valid |-> $past(read)
    );

endmodule

// File: design/voice_mixer.sv
module voice_mixer (
    input  logic                                  data_clk,
    input  logic                                  reset_data_N,
    input  logic signed [synth_pkg::SAMPLE_W-1:0] osc_sample [synth_pkg::V_OSC],
    input  logic                                  sample_valid,
    input  logic signed [synth_pkg::DATA_W-1:0]   osc_lvl [synth_pkg::V_OSC],
    input  logic signed [synth_pkg::DATA_W-1:0]   osc_pan [synth_pkg::V_OSC],
    input  logic signed [synth_pkg::DATA_W-1:0]   m_vol,
    output logic signed [synth_pkg::SAMPLE_W-1:0] left_out,
    output logic signed [synth_pkg::SAMPLE_W-1:0] right_out,
    output logic                                  out_valid
);
    import synth_pkg::*;

    logic signed [SAMPLE_W+DATA_W-1:0]  lvl_prod [V_OSC];
    logic signed [SAMPLE_W-1:0]         voice_s1 [V_OSC];
    logic signed [DATA_W-1:0]           pan_s1   [V_OSC];
    logic signed [DATA_W-1:0]           vol_s1;
    logic                               valid_s1;
    logic signed [MIX_SUM_W-1:0]        acc_l;
    logic signed [MIX_SUM_W-1:0]        acc_r;
    logic signed [MIX_SUM_W-1:0]        sum_l_s2;
    logic signed [MIX_SUM_W-1:0]        sum_r_s2;
    logic signed [DATA_W-1:0]           vol_s2;
    logic                               valid_s2;
    logic signed [MIX_SUM_W+DATA_W-1:0] vol_l;
    logic signed [MIX_SUM_W+DATA_W-1:0] vol_r;

    // negative parameters count as zero
    function automatic logic signed [DATA_W-1:0] clamp_prm(input logic signed [DATA_W-1:0] p);
        return p[DATA_W-1] ? '0 : p;
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] sat_sample(
        input logic signed [MIX_SUM_W+DATA_W-1:0] v
    );
        if (v > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end else if (v < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return v[SAMPLE_W-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < V_OSC; i++) begin
            lvl_prod[i] = osc_sample[i] * clamp_prm(osc_lvl[i]);
        end
    end

    always_ff @(posedge data_clk) begin
        if (sample_valid) begin
            for (int i = 0; i < V_OSC; i++) begin
                voice_s1[i] <= SAMPLE_W'(lvl_prod[i] >>> PRM_SHIFT);
                pan_s1[i]   <= clamp_prm(osc_pan[i]);
            end
            vol_s1 <= clamp_prm(m_vol);
        end
    end

    always_comb begin : pan_sum
        logic signed [SAMPLE_W+DATA_W-1:0] prod_l;
        logic signed [SAMPLE_W+DATA_W-1:0] prod_r;
        acc_l = '0;
        acc_r = '0;
        for (int i = 0; i < V_OSC; i++) begin
            prod_l = voice_s1[i] * (PRM_MAX - pan_s1[i]);
            prod_r = voice_s1[i] * pan_s1[i];
            acc_l  = acc_l + MIX_SUM_W'(prod_l >>> PRM_SHIFT);
            acc_r  = acc_r + MIX_SUM_W'(prod_r >>> PRM_SHIFT);
        end
    end

    always_ff @(posedge data_clk) begin
        if (valid_s1) begin
            sum_l_s2 <= acc_l;
            sum_r_s2 <= acc_r;
            vol_s2   <= vol_s1;
        end
    end

    assign vol_l = (sum_l_s2 * vol_s2) >>> PRM_SHIFT;
    assign vol_r = (sum_r_s2 * vol_s2) >>> PRM_SHIFT;

    always_ff @(posedge data_clk) begin
        if (valid_s2) begin
            left_out  <= sat_sample(vol_l);
            right_out <= sat_sample(vol_r);
        end
    end

    always_ff @(posedge data_clk) begin
        if (!reset_data_N) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_s1  <= sample_valid;
            valid_s2  <= valid_s1;
            out_valid <= valid_s2;
        end
    end

    a_latency_fwd: assert property (
        @(posedge data_clk) disable iff (!reset_data_N)
        sample_valid |-> ##3 out_valid
    );

    a_latency_back: assert property (
        @(posedge data_clk) disable iff (!reset_data_N)
        out_valid |-> $past(sample_valid, 3)
    );

endmodule

// File: design/synth_ctrl_top.sv
module synth_ctrl_top (
    input  logic                                  data_clk,
    input  logic                                  reset_data_N,
    input  logic [7:0]                            midi_byte,
    input  logic                                  midi_valid,
    input  synth_pkg::param_bank_e                rd_bank,
    input  logic [synth_pkg::ADR_W-1:0]           rd_adr,
    input  logic                                  read,
    output logic signed [synth_pkg::DATA_W-1:0]   rd_data,
    output logic                                  rd_valid,
    input  logic signed [synth_pkg::SAMPLE_W-1:0] osc_sample [synth_pkg::V_OSC],
    input  logic                                  sample_valid,
    output logic signed [synth_pkg::SAMPLE_W-1:0] left_out,
    output logic signed [synth_pkg::SAMPLE_W-1:0] right_out,
    output logic                                  out_valid
);
    import synth_pkg::*;

    logic signed [DATA_W-1:0] osc_lvl [V_OSC];
    logic signed [DATA_W-1:0] osc_pan [V_OSC];
    logic signed [DATA_W-1:0] m_vol;

    param_wr_if wr_bus ();

    midi_cc_decoder decoder_i (
        .data_clk     (data_clk),
        .reset_data_N (reset_data_N),
        .midi_byte    (midi_byte),
        .midi_valid   (midi_valid),
        .wr           (wr_bus.source)
    );

    midi_ctrl_data regs_i (
        .data_clk     (data_clk),
        .reset_data_N (reset_data_N),
        .wr           (wr_bus.sink),
        .rd_bank      (rd_bank),
        .rd_adr       (rd_adr),
        .read         (read),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .osc_lvl      (osc_lvl),
        .osc_pan      (osc_pan),
        .m_vol        (m_vol)
    );

    // parameters reach the mixer straight from the register outputs
    voice_mixer mixer_i (
        .data_clk     (data_clk),
        .reset_data_N (reset_data_N),
        .osc_sample   (osc_sample),
        .sample_valid (sample_valid),
        .osc_lvl      (osc_lvl),
        .osc_pan      (osc_pan),
        .m_vol        (m_vol),
        .left_out     (left_out),
        .right_out    (right_out),
        .out_valid    (out_valid)
    );

endmodule

// File: tb/tb_synth_ctrl.sv
module tb_synth_ctrl;
    import synth_pkg::*;

    localparam int READ_TIMEOUT   = 8;
    localparam int SAMPLE_TIMEOUT = 64;

    localparam int PS_IDLE = 0;
    localparam int PS_NUM  = 1;
    localparam int PS_VAL  = 2;

    typedef enum logic [1:0] {
        OP_MIDI,
        OP_READ,
        OP_SAMP,
        OP_IDLE
    } op_e;

    // read uses a as bank, b as address and c as the expected value
    // samples use a as the number of sets and b as the fill mode
    typedef struct packed {
        op_e        op;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
    } step_t;

    logic                       data_clk;
    logic                       reset_data_N;
    logic [7:0]                 midi_byte;
    logic                       midi_valid;
    param_bank_e                rd_bank;
    logic [ADR_W-1:0]           rd_adr;
    logic                       read;
    logic signed [DATA_W-1:0]   rd_data;
    logic                       rd_valid;
    logic signed [SAMPLE_W-1:0] osc_sample [V_OSC];
    logic                       sample_valid;
    logic signed [SAMPLE_W-1:0] left_out;
    logic signed [SAMPLE_W-1:0] right_out;
    logic                       out_valid;

    step_t      steps [$];
    logic [7:0] regs [4][128];
    int         cur_smp [V_OSC];
    int         exp_l [$];
    int         exp_r [$];
    int         due_cyc [$];
    int         p_state;
    logic [6:0] p_num;
    logic [1:0] p_bank;
    logic [6:0] p_adr;
    int         seed;
    int         cyc;
    int         errors;
    int         timeouts;

    synth_ctrl_top dut_i (
        .data_clk     (data_clk),
        .reset_data_N (reset_data_N),
        .midi_byte    (midi_byte),
        .midi_valid   (midi_valid),
        .rd_bank      (rd_bank),
        .rd_adr       (rd_adr),
        .read         (read),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .osc_sample   (osc_sample),
        .sample_valid (sample_valid),
        .left_out     (left_out),
        .right_out    (right_out),
        .out_valid    (out_valid)
    );

    initial begin
        data_clk = 1'b0;
        forever #10 data_clk = ~data_clk;
    end

    always @(posedge data_clk) begin
        cyc <= cyc + 1;
    end

    task automatic append_step(input op_e op, input logic [7:0] a, input logic [7:0] b,
                               input logic [7:0] c);
        step_t s;
        s.op = op;
        s.a  = a;
        s.b  = b;
        s.c  = c;
        steps.push_back(s);
    endtask

    task automatic midi_in(input logic [7:0] value);
        append_step(OP_MIDI, value, 8'h00, 8'h00);
    endtask

    task automatic idle_for(input logic [7:0] n);
        append_step(OP_IDLE, n, 8'h00, 8'h00);
    endtask

    task automatic expect_read(input logic [7:0] bank, input logic [7:0] adr,
                               input logic [7:0] value);
        append_step(OP_READ, bank, adr, value);
    endtask

    task automatic sample_burst(input logic [7:0] n, input logic [7:0] mode);
        append_step(OP_SAMP, n, mode, 8'h00);
    endtask

    // a complete select and data entry message, then one cycle for the write to land
    task automatic nrpn_write(input logic [7:0] bank, input logic [7:0] adr,
                              input logic [7:0] value);
        midi_in(8'hB0);
        midi_in(8'd99);
        midi_in(bank);
        midi_in(8'd98);
        midi_in(adr);
        midi_in(8'd6);
        midi_in(value);
        idle_for(8'd1);
    endtask

    task automatic build_table();
        for (int i = 0; i < 4; i++) begin
            expect_read(8'd0, 8'(i * 16 + 2), (i < 2) ? 8'h40 : 8'h00);
            expect_read(8'd0, 8'(i * 16 + 7), 8'h40);
        end
        expect_read(8'd0, 8'h03, 8'h00);
        expect_read(8'd0, 8'h3B, 8'h00);
        expect_read(8'd1, 8'd1, 8'h40);
        expect_read(8'd1, 8'd16, 8'h20);
        expect_read(8'd1, 8'd31, 8'h20);
        expect_read(8'd1, 8'd0, 8'h00);
        expect_read(8'd2, 8'd0, 8'h00);
        expect_read(8'd3, 8'd63, 8'h00);
        nrpn_write(8'd0, 8'h13, 8'h55);
        nrpn_write(8'd0, 8'h3A, 8'h11);
        expect_read(8'd0, 8'h13, 8'h55);
        expect_read(8'd0, 8'h3A, 8'h11);
        // running status across four controller messages, realtime bytes mixed in
        midi_in(8'hB0);
        midi_in(8'd99);
        midi_in(8'd1);
        midi_in(8'd98);
        midi_in(8'hF8);
        midi_in(8'd20);
        midi_in(8'd6);
        midi_in(8'h41);
        midi_in(8'd98);
        midi_in(8'd21);
        midi_in(8'd6);
        midi_in(8'hFE);
        midi_in(8'h42);
        idle_for(8'd1);
        expect_read(8'd1, 8'd20, 8'h41);
        expect_read(8'd1, 8'd21, 8'h42);
        nrpn_write(8'd2, 8'd37, 8'h09);
        nrpn_write(8'd3, 8'd63, 8'h7F);
        expect_read(8'd2, 8'd37, 8'h09);
        expect_read(8'd3, 8'd63, 8'h7F);
        expect_read(8'd2, 8'd63, 8'h00);
        // bank byte 5 selects the common bank through its low two bits
        nrpn_write(8'd5, 8'd1, 8'h30);
        expect_read(8'd1, 8'd1, 8'h30);
        midi_in(8'hB1);
        midi_in(8'd99);
        midi_in(8'd0);
        midi_in(8'd98);
        midi_in(8'd2);
        midi_in(8'd6);
        midi_in(8'h10);
        midi_in(8'hB0);
        midi_in(8'd7);
        midi_in(8'h64);
        midi_in(8'h90);
        midi_in(8'h3C);
        midi_in(8'h64);
        midi_in(8'd6);
        midi_in(8'h10);
        idle_for(8'd1);
        expect_read(8'd0, 8'd2, 8'h40);
        expect_read(8'd1, 8'd1, 8'h30);
        nrpn_write(8'd0, 8'd5, 8'h4D);
        nrpn_write(8'd0, 8'h42, 8'h4D);
        nrpn_write(8'd1, 8'd40, 8'h4D);
        nrpn_write(8'd2, 8'h64, 8'h4D);
        expect_read(8'd0, 8'd5, 8'h00);
        expect_read(8'd0, 8'h42, 8'h00);
        expect_read(8'd0, 8'd2, 8'h40);
        expect_read(8'd1, 8'd40, 8'h00);
        expect_read(8'd2, 8'h64, 8'h00);
        expect_read(8'd2, 8'h24, 8'h00);
        nrpn_write(8'd0, 8'h02, 8'd100);
        nrpn_write(8'd0, 8'h12, 8'd127);
        nrpn_write(8'd0, 8'h22, 8'd64);
        nrpn_write(8'd0, 8'h32, 8'd90);
        nrpn_write(8'd0, 8'h07, 8'd0);
        nrpn_write(8'd0, 8'h17, 8'd127);
        nrpn_write(8'd0, 8'h27, 8'd64);
        nrpn_write(8'd0, 8'h37, 8'd30);
        nrpn_write(8'd1, 8'd1, 8'd110);
        sample_burst(8'd12, 8'd0);
        idle_for(8'd2);
        sample_burst(8'd1, 8'd0);
        for (int i = 0; i < 4; i++) begin
            nrpn_write(8'd0, 8'(i * 16 + 2), 8'd127);
            nrpn_write(8'd0, 8'(i * 16 + 7), 8'd127);
        end
        nrpn_write(8'd1, 8'd1, 8'd127);
        sample_burst(8'd2, 8'd1);
        sample_burst(8'd2, 8'd2);
        // data entry carries 7 bits, so pan 0 stands in for a negative pan
        for (int i = 0; i < 4; i++) begin
            nrpn_write(8'd0, 8'(i * 16 + 7), 8'd0);
        end
        sample_burst(8'd2, 8'd1);
        sample_burst(8'd3, 8'd0);
    endtask

    task automatic reset_model();
        for (int b = 0; b < 4; b++) begin
            for (int a = 0; a < 128; a++) begin
                regs[b][a] = 8'h00;
            end
        end
        for (int i = 0; i < 4; i++) begin
            regs[0][i * 16 + 2] = (i < 2) ? 8'h40 : 8'h00;
            regs[0][i * 16 + 7] = 8'h40;
        end
        regs[1][1] = 8'h40;
        p_state = PS_IDLE;
        p_num   = 7'd0;
        p_bank  = 2'd0;
        p_adr   = 7'd0;
    endtask

    // follows the controller stream the way a receiver on channel 0 would
    task automatic track_byte(input logic [7:0] value);
        if (value < 8'hF8) begin
            if (value[7]) begin
                p_state = (value == 8'hB0) ? PS_NUM : PS_IDLE;
            end else if (p_state == PS_NUM) begin
                p_num   = value[6:0];
                p_state = PS_VAL;
            end else if (p_state == PS_VAL) begin
                p_state = PS_NUM;
                if (p_num == 7'd99) begin
                    p_bank = value[1:0];
                end else if (p_num == 7'd98) begin
                    p_adr = value[6:0];
                end else if (p_num == 7'd6) begin
                    regs[p_bank][p_adr] = {1'b0, value[6:0]};
                end
            end
        end
    endtask

    function automatic int non_negative(input logic [7:0] p);
        if (p[7]) begin
            return 0;
        end
        return int'(p);
    endfunction

    function automatic int saturate(input int v);
        if (v > 32767) begin
            return 32767;
        end else if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    task automatic compute_mix(output int l, output int r);
        int voice;
        int lvl;
        int pan;
        int sum_l;
        int sum_r;
        sum_l = 0;
        sum_r = 0;
        for (int i = 0; i < 4; i++) begin
            lvl   = non_negative(regs[0][i * 16 + 2]);
            pan   = non_negative(regs[0][i * 16 + 7]);
            voice = (cur_smp[i] * lvl) >>> 7;
            sum_l = sum_l + ((voice * (127 - pan)) >>> 7);
            sum_r = sum_r + ((voice * pan) >>> 7);
        end
        l = saturate((sum_l * non_negative(regs[1][1])) >>> 7);
        r = saturate((sum_r * non_negative(regs[1][1])) >>> 7);
    endtask

    task automatic send_byte(input logic [7:0] value);
        midi_byte  = value;
        midi_valid = 1'b1;
        track_byte(value);
        @(posedge data_clk);
        #2;
        midi_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge data_clk);
            #2;
        end
    endtask

    task automatic check_read(input logic [1:0] bank, input logic [6:0] adr,
                              input logic [7:0] value);
        int waited;
        rd_bank = param_bank_e'(bank);
        rd_adr  = adr;
        read    = 1'b1;
        @(posedge data_clk);
        #2;
        read   = 1'b0;
        waited = 1;
        while (!rd_valid && waited < READ_TIMEOUT) begin
            @(posedge data_clk);
            #2;
            waited++;
        end
        if (!rd_valid) begin
            $display("timeout: rd_valid never rose after a read of bank %0d address %0d",
                     bank, adr);
            timeouts++;
        end else begin
            if (waited != 1) begin
                $display("** Error at %0t: rd_valid came %0d cycles after read", $time, waited);
                errors++;
            end
            if (rd_data !== value) begin
                $display("** Error at %0t: bank %0d address %0d read %02h, expected %02h",
                         $time, bank, adr, rd_data, value);
                errors++;
            end
            @(posedge data_clk);
            #2;
            if (rd_valid) begin
                $display("** Error at %0t: rd_valid stayed high for a second cycle", $time);
                errors++;
            end
        end
    endtask

    // mode 0 draws random samples, mode 1 is positive full scale, mode 2 negative
    task automatic run_samples(input int count, input logic [7:0] mode);
        int sent;
        int got;
        int waited;
        int rnd;
        int el;
        int er;
        int due;
        sent   = 0;
        got    = 0;
        waited = 0;
        while (got < count && waited < SAMPLE_TIMEOUT) begin
            if (sent < count) begin
                for (int i = 0; i < V_OSC; i++) begin
                    if (mode == 8'd1) begin
                        cur_smp[i] = 32767;
                    end else if (mode == 8'd2) begin
                        cur_smp[i] = -32768;
                    end else begin
                        rnd        = $random(seed);
                        cur_smp[i] = int'($signed(rnd[15:0]));
                    end
                    osc_sample[i] = cur_smp[i][15:0];
                end
                compute_mix(el, er);
                exp_l.push_back(el);
                exp_r.push_back(er);
                due_cyc.push_back(cyc + 3);
                sample_valid = 1'b1;
                sent++;
            end else begin
                sample_valid = 1'b0;
            end
            @(posedge data_clk);
            #2;
            waited++;
            if (out_valid) begin
                if (exp_l.size() == 0) begin
                    $display("** Error at %0t: out_valid without a sample set in flight", $time);
                    errors++;
                end else begin
                    el  = exp_l.pop_front();
                    er  = exp_r.pop_front();
                    due = due_cyc.pop_front();
                    if (cyc != due) begin
                        $display("** Error at %0t: output at cycle %0d, expected cycle %0d",
                                 $time, cyc, due);
                        errors++;
                    end
                    if (int'(left_out) != el || int'(right_out) != er) begin
                        $display("** Error at %0t: output %0d/%0d, expected %0d/%0d",
                                 $time, left_out, right_out, el, er);
                        errors++;
                    end
                    got++;
                end
            end
        end
        sample_valid = 1'b0;
        if (got < count) begin
            $display("timeout: only %0d of %0d mixer outputs arrived", got, count);
            timeouts++;
        end
    endtask

    initial begin
        seed         = 32'h9cb3e265;
        cyc          = 0;
        errors       = 0;
        timeouts     = 0;
        reset_data_N = 1'b0;
        midi_byte    = 8'h00;
        midi_valid   = 1'b0;
        rd_bank      = BANK_OSC;
        rd_adr       = '0;
        read         = 1'b0;
        sample_valid = 1'b0;
        for (int i = 0; i < V_OSC; i++) begin
            osc_sample[i] = '0;
        end
        reset_model();
        build_table();
        repeat (10) @(posedge data_clk);
        #2;
        reset_data_N = 1'b1;
        for (int k = 0; k < steps.size() && timeouts == 0; k++) begin
            case (steps[k].op)
                OP_MIDI: send_byte(steps[k].a);
                OP_READ: check_read(steps[k].a[1:0], steps[k].b[6:0], steps[k].c);
                OP_SAMP: run_samples(int'(steps[k].a), steps[k].b);
                OP_IDLE: idle_cycles(int'(steps[k].a));
                default: ;
            endcase
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/synth_pkg.sv
common/param_wr_if.sv
midi_ctrl/midi_cc_decoder.sv
midi_ctrl/midi_ctrl_data.sv
design/voice_mixer.sv
design/synth_ctrl_top.sv
tb/tb_synth_ctrl.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINT      = --lint-only -Wall --timing
TOP       = tb_synth_ctrl
RTL_TOP   = synth_ctrl_top
FLIST     = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
